// ==== hdl/vga_pkg.sv ====
// Video timing constants for 800x600 and the pixel bus struct.

`default_nettype none

package vga_pkg;

    //////////////////////////////////////////////////
    // 800x600 at 60 Hz, 40 MHz pixel clock.
    //////////////////////////////////////////////////

    // Visible area.
    localparam int hor_pixels = 800;
    localparam int ver_pixels = 600;

    // Horizontal line, in pixel clocks.
    localparam int hor_total      = 1056;
    localparam int hor_sync_start = 840;
    localparam int hor_sync_end   = 968;   // First pixel after the pulse.

    // Vertical frame, in lines.
    localparam int ver_total      = 628;
    localparam int ver_sync_start = 601;
    localparam int ver_sync_end   = 605;   // First line after the pulse.

    //////////////////////////////////////////////////
    // Pixel bus, one pixel per clock.
    //////////////////////////////////////////////////

    // Sync polarity is positive for this mode.
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        hblnk;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;     // 4 bits each of red, green, blue.
    } vga_bus_t;

endpackage

`default_nettype wire

// ==== hdl/game_pkg.sv ====
// Game state and class encodings, button geometry, colours and click cooldown.

`default_nettype none

package game_pkg;

    //////////////////////////////////////////////////
    // Encodings.
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        st_menu = 2'd0,
        st_play = 2'd1,
        st_over = 2'd2
    } game_state_t;

    // Zero means no class chosen yet.
    typedef logic [1:0] char_class_t;

    //////////////////////////////////////////////////
    // Button geometry and timing.
    //////////////////////////////////////////////////

    // Centred horizontally, a third of the way down.
    localparam int btn_x     = 337;
    localparam int btn_y     = 175;
    localparam int btn_w     = 125;
    localparam int btn_h     = 75;
    localparam int btn_frame = 2;       // Frame width, also the corner size.

    localparam int click_cooldown = 20; // Clock cycles.

    //////////////////////////////////////////////////
    // Colours, 12-bit RGB.
    //////////////////////////////////////////////////

    localparam logic [11:0] col_sky         = 12'h48f;
    localparam logic [11:0] col_ground      = 12'h6a3;
    localparam int          ground_line     = 450;
    localparam logic [11:0] col_frame       = 12'hfff;
    localparam logic [11:0] col_start       = 12'h0c0;
    localparam logic [11:0] col_again       = 12'hf80;
    localparam logic [11:0] col_transparent = 12'h000;

endpackage

`default_nettype wire

// ==== hdl/vga_timing.sv ====
// VGA timing generator with registered counters, syncs and blanking.

`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output vga_bus_t vga
);

    //////////////////////////////////////////////////
    // Next counter values.
    //////////////////////////////////////////////////

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;

    always_comb begin
        hcount_nxt = vga.hcount + 11'd1;
        vcount_nxt = vga.vcount;
        if (vga.hcount == 11'(hor_total - 1)) begin
            hcount_nxt = 11'd0;
            // End of line, step the line counter.
            if (vga.vcount == 11'(ver_total - 1)) begin
                vcount_nxt = 11'd0;
            end else begin
                vcount_nxt = vga.vcount + 11'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Registered outputs.
    //////////////////////////////////////////////////

    // Syncs and blanking come from the next counts, so they line up
    // with the registered counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount <= hcount_nxt;
            vga.vcount <= vcount_nxt;
            vga.hsync  <= (hcount_nxt >= 11'(hor_sync_start)) &&
                          (hcount_nxt <  11'(hor_sync_end));
            vga.hblnk  <= (hcount_nxt >= 11'(hor_pixels));
            vga.vsync  <= (vcount_nxt >= 11'(ver_sync_start)) &&
                          (vcount_nxt <  11'(ver_sync_end));
            vga.vblnk  <= (vcount_nxt >= 11'(ver_pixels));
            vga.rgb    <= 12'h000;             // Painted downstream.
        end
    end

    //////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////

    // Line wrap must happen before the counter leaves the line.
    hcount_in_line: assert property (
        @(posedge clk) disable iff (rst) vga.hcount < 11'(hor_total)
    ) else $error("hcount reached hor_total");

endmodule

`default_nettype wire

// ==== hdl/draw_background.sv ====
// Background painter, sky above the ground line and ground below.

`timescale 1ns/1ps
`default_nettype none

module draw_background
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  vga_bus_t vga_in,
    output vga_bus_t vga_out
);

    logic [11:0] rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = 12'h000;                  // Black in blanking.
        end else if (vga_in.vcount < 11'(ground_line)) begin
            rgb_nxt = col_sky;
        end else begin
            rgb_nxt = col_ground;
        end
    end

    // One stage, whole bus moves together.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/button_sprite.sv ====
// Rule-based button art, framed box with rounded corners in two kinds.

`timescale 1ns/1ps
`default_nettype none

module button_sprite
    import game_pkg::*;
(
    input  logic [6:0]  rel_x,
    input  logic [6:0]  rel_y,
    input  logic        again,
    output logic [11:0] color
);

    logic edge_x;
    logic edge_y;
    logic corner;
    logic frame;

    // Near the left or right border.
    assign edge_x = (rel_x < 7'(btn_frame)) || (rel_x >= 7'(btn_w - btn_frame));

    // Near the top or bottom border.
    assign edge_y = (rel_y < 7'(btn_frame)) || (rel_y >= 7'(btn_h - btn_frame));

    assign corner = edge_x && edge_y;
    assign frame  = edge_x || edge_y;

    always_comb begin
        if (corner) begin
            color = col_transparent;            // Rounds the corners off.
        end else if (frame) begin
            color = col_frame;
        end else if (again) begin
            color = col_again;
        end else begin
            color = col_start;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/game_screen.sv ====
// Start and again button overlay with qualified click detection.

`timescale 1ns/1ps
`default_nettype none

module game_screen
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  game_state_t game_state,
    input  char_class_t char_class,
    input  char_class_t player_2_class,
    input  logic        player_2_data_valid,
    input  logic        mouse_clicked,
    input  logic [11:0] mouse_x,
    input  logic [11:0] mouse_y,
    output logic        game_start,
    input  vga_bus_t    vga_in,
    output vga_bus_t    vga_out
);

    //////////////////////////////////////////////////
    // Button overlay.
    //////////////////////////////////////////////////

    logic        pix_in_rect;
    logic [6:0]  rel_x;
    logic [6:0]  rel_y;
    logic [11:0] sprite_color;
    logic        show_btn;
    logic [11:0] rgb_nxt;

    assign pix_in_rect = (vga_in.hcount >= 11'(btn_x)) &&
                         (vga_in.hcount <  11'(btn_x + btn_w)) &&
                         (vga_in.vcount >= 11'(btn_y)) &&
                         (vga_in.vcount <  11'(btn_y + btn_h));

    // Only meaningful inside the rectangle.
    assign rel_x = 7'(vga_in.hcount - 11'(btn_x));
    assign rel_y = 7'(vga_in.vcount - 11'(btn_y));

    button_sprite sprite_i (
        .rel_x (rel_x),
        .rel_y (rel_y),
        .again (game_state == st_over),
        .color (sprite_color)
    );

    assign show_btn = (game_state != st_play) && pix_in_rect &&
                      (sprite_color != col_transparent);
    assign rgb_nxt  = show_btn ? sprite_color : vga_in.rgb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Click detection.
    //////////////////////////////////////////////////

    logic                                  mouse_in_rect;
    logic                                  classes_ok;
    logic                                  click_ok;
    logic [$clog2(click_cooldown + 1)-1:0] cooldown;

    assign mouse_in_rect = (mouse_x >= 12'(btn_x)) && (mouse_x < 12'(btn_x + btn_w)) &&
                           (mouse_y >= 12'(btn_y)) && (mouse_y < 12'(btn_y + btn_h));

    // Player 2 must pick a different class when present.
    assign classes_ok = (char_class != '0) &&
                        (!player_2_data_valid ||
                         ((player_2_class != '0) && (player_2_class != char_class)));

    assign click_ok = mouse_clicked && mouse_in_rect && (cooldown == '0) &&
                      ((game_state == st_over) || ((game_state == st_menu) && classes_ok));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_start <= 1'b0;
            cooldown   <= '0;
        end else begin
            game_start <= click_ok;
            if (click_ok) begin
                cooldown <= ($clog2(click_cooldown + 1))'(click_cooldown);
            end else if (cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end
        end
    end

    // The cooldown keeps a start to a single cycle.
    start_one_cycle: assert property (
        @(posedge clk) disable iff (rst) game_start |=> !game_start
    ) else $error("game_start held for two cycles");

    // The controller is never in play while a start is pending.
    start_not_in_play: assert property (
        @(posedge clk) disable iff (rst) game_start |-> (game_state != st_play)
    ) else $error("game_start raised in st_play");

endmodule

`default_nettype wire

// ==== hdl/game_state_ctrl.sv ====
// Game state FSM for menu, play and game-over.

`timescale 1ns/1ps
`default_nettype none

module game_state_ctrl
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        game_start,
    input  logic        round_lost,
    output game_state_t game_state
);

    game_state_t state_nxt;

    //////////////////////////////////////////////////
    // Next state.
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = game_state;
        unique case (game_state)
            st_menu: begin
                if (game_start) begin
                    state_nxt = st_play;
                end
            end
            st_play: begin
                if (round_lost) begin
                    state_nxt = st_over;
                end
            end
            st_over: begin
                // Back to class selection.
                if (game_start) begin
                    state_nxt = st_menu;
                end
            end
            default: state_nxt = st_menu;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= st_menu;
        end else begin
            game_state <= state_nxt;
        end
    end

    legal_state: assert property (
        @(posedge clk) disable iff (rst) game_state != 2'd3
    ) else $error("Illegal game state encoding");

endmodule

`default_nettype wire

// ==== hdl/game_top.sv ====
// Top level of the menu layer, timing, background, button screen and FSM.

`timescale 1ns/1ps
`default_nettype none

module game_top
    import vga_pkg::*;
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        mouse_clicked,
    input  logic        round_lost,
    input  logic        player_2_data_valid,
    input  logic [11:0] mouse_x,
    input  logic [11:0] mouse_y,
    input  char_class_t char_class,
    input  char_class_t player_2_class,
    output vga_bus_t    vga,
    output game_state_t game_state
);

    vga_bus_t vga_tim;   // Counters and syncs only.
    vga_bus_t vga_bg;    // Background painted.
    logic     game_start;

    //////////////////////////////////////////////////
    // Pixel path.
    //////////////////////////////////////////////////

    vga_timing timing_i (
        .clk (clk),
        .rst (rst),
        .vga (vga_tim)
    );

    draw_background background_i (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (vga_tim),
        .vga_out (vga_bg)
    );

    game_screen screen_i (
        .clk                 (clk),
        .rst                 (rst),
        .game_state          (game_state),
        .char_class          (char_class),
        .player_2_class      (player_2_class),
        .player_2_data_valid (player_2_data_valid),
        .mouse_clicked       (mouse_clicked),
        .mouse_x             (mouse_x),
        .mouse_y             (mouse_y),
        .game_start          (game_start),
        .vga_in              (vga_bg),
        .vga_out             (vga)
    );

    // Game flow.
    game_state_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .game_start (game_start),
        .round_lost (round_lost),
        .game_state (game_state)
    );

endmodule

`default_nettype wire

// ==== verification/game_tb.sv ====
// Testbench for the menu layer with clock, reset, golden record reader, checks and report.

`timescale 1ns/1ps
`default_nettype none

module game_tb
    import vga_pkg::*;
    import game_pkg::*;
();

    localparam string golden_file  = "verification/game_golden.dat";
    localparam int    reset_cycles = 16;
    localparam int    frame_cycles = hor_total * ver_total;

    logic        clk;
    logic        rst;
    logic        mouse_clicked;
    logic        round_lost;
    logic        player_2_data_valid;
    logic [11:0] mouse_x;
    logic [11:0] mouse_y;
    char_class_t char_class;
    char_class_t player_2_class;
    vga_bus_t    vga;
    game_state_t game_state;

    string records[$];      // Golden lines, comments dropped.
    int    tests       = 0;
    int    errors      = 0;
    int    sync_errors = 0;
    int    cycle_count = 0;
    int    cycle_limit = 0; // Zero until the records are counted.

    game_top dut_i (
        .clk                 (clk),
        .rst                 (rst),
        .mouse_clicked       (mouse_clicked),
        .round_lost          (round_lost),
        .player_2_data_valid (player_2_data_valid),
        .mouse_x             (mouse_x),
        .mouse_y             (mouse_y),
        .char_class          (char_class),
        .player_2_class      (player_2_class),
        .vga                 (vga),
        .game_state          (game_state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 25 MHz in sim time, 40 ns period.
    end

    //////////////////////////////////////////////////
    // Watchdog and run control.
    //////////////////////////////////////////////////

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
            stop_failed($sformatf("Simulation timed out after %0d cycles.", cycle_count));
        end
    end

    function automatic bit is_record(input string line);
        return (line.len() > 0) && (line[0] != "#") && (line[0] != "\r");
    endfunction

    task automatic load_records(input int fd);
        string line;
        int    code;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if ((code > 0) && (line[line.len() - 1] == "\n")) begin
                line = line.substr(0, line.len() - 2);
            end
            if ((code > 0) && is_record(line)) begin
                records.push_back(line);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Reporting.
    //////////////////////////////////////////////////

    task automatic report_test(input string what, input bit ok, input string detail);
        tests++;
        if (!ok) begin
            errors++;
            $display("[ERROR] at %0d ns: %s, %s", $time, what, detail);
        end
        $display("Test %0d (%s): %s", tests, what, ok ? "ok" : "FAILED");
    endtask

    task automatic reject_record(input string line);
        tests++;
        errors++;
        $display("Test %0d: golden record could not be read: %s", tests, line);
    endtask

    task automatic check_state(input string what, input int exp_state);
        if (game_state != 2'(exp_state)) begin
            report_test(what, 1'b0, $sformatf("state %0d, expected %0d", game_state, exp_state));
        end else begin
            report_test(what, 1'b1, "");
        end
    endtask

    //////////////////////////////////////////////////
    // Sync and blanking monitor.
    //////////////////////////////////////////////////

    // Positive syncs; order is hsync, hblnk, vsync, vblnk.
    function automatic logic [3:0] sync_flags(input int h, input int v);
        return {(h >= hor_sync_start) && (h < hor_sync_end),
                h >= hor_pixels,
                (v >= ver_sync_start) && (v < ver_sync_end),
                v >= ver_pixels};
    endfunction

    always @(negedge clk) begin
        if (!rst && ({vga.hsync, vga.hblnk, vga.vsync, vga.vblnk} !=
                     sync_flags(vga.hcount, vga.vcount))) begin
            sync_errors++;
            if (sync_errors == 1) begin
                $display("[ERROR] at %0d ns: sync or blanking wrong at %0d,%0d",
                         $time, vga.hcount, vga.vcount);
            end
        end
    end

    //////////////////////////////////////////////////
    // Record handlers.
    //////////////////////////////////////////////////

    task automatic click_button(input string line);
        int x;
        int y;
        int cls;
        int p2_cls;
        int p2_valid;
        int exp_state;
        if ($sscanf(line, "C %d %d %d %d %d %d", x, y, cls, p2_cls, p2_valid, exp_state) != 6) begin
            reject_record(line);
        end else begin
            @(posedge clk);
            mouse_x             <= 12'(x);
            mouse_y             <= 12'(y);
            char_class          <= 2'(cls);
            player_2_class      <= 2'(p2_cls);
            player_2_data_valid <= (p2_valid != 0);
            mouse_clicked       <= 1'b1;
            @(posedge clk);
            mouse_clicked <= 1'b0;        // One cycle pulse.
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_state($sformatf("click %0d,%0d", x, y), exp_state);
        end
    endtask

    task automatic lose_round(input string line);
        int exp_state;
        if ($sscanf(line, "L %d", exp_state) != 1) begin
            reject_record(line);
        end else begin
            @(posedge clk);
            round_lost <= 1'b1;
            @(posedge clk);
            round_lost <= 1'b0;
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_state("round lost", exp_state);
        end
    endtask

    task automatic check_pixel(input string line);
        int          h;
        int          v;
        logic [11:0] exp_rgb;
        if ($sscanf(line, "P %d %d %h", h, v, exp_rgb) != 3) begin
            reject_record(line);
        end else begin
            // Coordinates travel with the colour, so wait for them.
            @(negedge clk);
            while (!((vga.hcount == 11'(h)) && (vga.vcount == 11'(v)))) begin
                @(negedge clk);
            end
            if (vga.rgb != exp_rgb) begin
                report_test($sformatf("pixel %0d,%0d", h, v), 1'b0,
                            $sformatf("rgb %h, expected %h", vga.rgb, exp_rgb));
            end else begin
                report_test($sformatf("pixel %0d,%0d", h, v), 1'b1, "");
            end
        end
    endtask

    task automatic wait_cycles(input string line);
        int n;
        if ($sscanf(line, "W %d", n) != 1) begin
            reject_record(line);
        end else begin
            repeat (n) @(posedge clk);
            $display("Waited %0d cycles.", n);
        end
    endtask

    task automatic run_record(input string line);
        case (line[0])
            "C":     click_button(line);
            "L":     lose_round(line);
            "P":     check_pixel(line);
            "W":     wait_cycles(line);
            default: reject_record(line);
        endcase
    endtask

    //////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////

    initial begin : main
        int    fd;
        int    n_pixel;
        string line;
        n_pixel             = 0;
        rst                 <= 1'b1;
        mouse_clicked       <= 1'b0;
        round_lost          <= 1'b0;
        player_2_data_valid <= 1'b0;
        mouse_x             <= 12'd0;
        mouse_y             <= 12'd0;
        char_class          <= 2'd0;
        player_2_class      <= 2'd0;
        fd = $fopen(golden_file, "r");
        if (fd == 0) begin
            stop_failed({"Could not open ", golden_file, "."});
        end else begin
            load_records(fd);
            $fclose(fd);
            foreach (records[i]) begin
                line = records[i];
                if (line[0] == "P") begin
                    n_pixel++;
                end
            end
            // A pixel may be nearly a frame away; other records are short.
            cycle_limit = reset_cycles + 3 * frame_cycles * n_pixel +
                          100 * (records.size() - n_pixel);
            repeat (reset_cycles) @(posedge clk);
            rst <= 1'b0;
            foreach (records[i]) begin
                run_record(records[i]);
            end
            report_test("sync and blanking", sync_errors == 0,
                        $sformatf("%0d cycles with wrong flags", sync_errors));
            $display("Tests run: %0d, errors: %0d", tests, errors);
            if ((errors == 0) && (tests > 0)) begin
                $display("Regression passed");
                $finish;
            end else begin
                stop_failed("Some checks failed or no test ran.");
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/game_golden.dat ====
# C x y char_class p2_class p2_valid exp_state | L exp_state | W cycles
# P hcount vcount exp_rgb(hex); states 0 menu, 1 play, 2 over
P 100 100 48f
P 900 100 000
P 337 175 48f
P 400 175 fff
P 338 200 fff
P 400 210 0c0
P 461 249 48f
P 100 500 6a3
C 400 210 0 0 0 0
C 400 210 1 1 1 0
C 400 210 1 0 1 0
C 300 210 1 2 1 0
C 400 210 1 2 1 1
P 400 175 48f
P 400 210 48f
L 2
P 400 210 f80
P 400 249 fff
C 400 210 0 0 0 0
W 25
C 400 210 3 1 1 1
L 2
C 400 210 3 1 1 2
W 20
C 400 210 0 0 0 0
P 400 210 0c0

// ==== tb.f ====
hdl/vga_pkg.sv
hdl/game_pkg.sv
hdl/vga_timing.sv
hdl/draw_background.sv
hdl/button_sprite.sv
hdl/game_screen.sv
hdl/game_state_ctrl.sv
hdl/game_top.sv
verification/game_tb.sv

// ==== Makefile ====
# Verilator build and run for the menu layer testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= game_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line.
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
